// ==== hw/dmaPkg.sv ====
// Shared widths, CPU register port map and read source type for the DMA datapath RTL
`default_nettype none

package dmaPkg;

  // Data and address widths with a meaning of their own
  typedef logic [7:0]  byteT;
  typedef logic [15:0] addrWordT;
  typedef logic [15:0] countT;
  typedef logic [3:0]  regPortT;
  typedef logic [1:0]  chanT;

  // What the readback stage returns on a CPU read
  typedef enum logic [1:0] {
    ReadNone,
    ReadAddr,
    ReadCount,
    ReadStatus
  } readSrcT;

  // Channel block: port 2n is the address, port 2n+1 the count of channel n
  localparam regPortT PortAddrBase  = 4'd0;
  localparam regPortT PortCountBase = 4'd1;

  // First port past the channel block, also the status register
  localparam regPortT PortStatus = 4'd8;

  // Command ports, all write only
  localparam regPortT PortSingleMask    = 4'd10;
  localparam regPortT PortMode          = 4'd11;
  localparam regPortT PortClearFlipFlop = 4'd12;
  localparam regPortT PortMasterClear   = 4'd13;
  localparam regPortT PortClearMask     = 4'd14;
  localparam regPortT PortAllMask       = 4'd15;

  // Mode byte fields that take effect
  // Bits 1:0 of the mode byte select the channel
  localparam int ModeAutoInitBit  = 4;
  localparam int ModeDecrementBit = 5;

  // Single mask byte: bits 1:0 select the channel, bit 2 is the new mask value
  localparam int SingleMaskSetBit = 2;

endpackage

`default_nettype wire

// ==== hw/chanBusIf.sv ====
// Per-channel bus from the CPU port decoder into one channel and out to the readback stage
`timescale 1ns/1ps
`default_nettype none

interface chanBusIf;

  // Register write and step strobes, one cycle each
  dmaPkg::byteT wrData;
  logic         hiByte;
  logic         wrAddr;
  logic         wrCount;
  logic         wrMode;
  logic         step;
  logic         clear;

  // Channel state and step results
  dmaPkg::addrWordT currAddr;
  dmaPkg::countT    currCount;
  dmaPkg::addrWordT stepAddr;
  logic             stepDone;
  logic             tcHit;

  modport decoder (
    output wrData, hiByte, wrAddr, wrCount, wrMode, step, clear
  );

  modport channel (
    input  wrData, hiByte, wrAddr, wrCount, wrMode, step, clear,
    output currAddr, currCount, stepAddr, stepDone, tcHit
  );

  modport readback (
    input currAddr, currCount, stepAddr, stepDone, tcHit
  );

endinterface

`default_nettype wire

// ==== hw/cpuPortDecoder.sv ====
// CPU port decoder: samples the bus, keeps byte pointer and mask, and strobes the channels
`timescale 1ns/1ps
`default_nettype none

module cpuPortDecoder #(
  parameter int NumChannels = 4
) (
  input  logic             dma_if,
  input  logic             rstN,
  input  logic             csN,
  input  logic             iorN,
  input  logic             iowN,
  input  dmaPkg::regPortT  regPort,
  input  dmaPkg::byteT     dataIn,
  input  logic             stepReq,
  input  dmaPkg::chanT     stepChan,
  output dmaPkg::readSrcT  readSrc,
  output dmaPkg::chanT     readChan,
  output logic             readHi,
  output logic             statusClear,
  chanBusIf.decoder        chan [NumChannels]
);

  logic         wrEn;
  logic         rdEn;
  logic         bytePtr;
  logic [3:0]   mask;
  dmaPkg::chanT portChan;
  dmaPkg::chanT modeChan;
  logic         portIsChan;
  logic         addrHit;
  logic         countHit;
  logic         stepOk;

  // Registered strobes, one bit per channel
  logic [NumChannels-1:0] wrAddrQ;
  logic [NumChannels-1:0] wrCountQ;
  logic [NumChannels-1:0] wrModeQ;
  logic [NumChannels-1:0] stepQ;
  logic                   clearQ;

  // Payload that travels with the strobes
  dmaPkg::byteT wrDataQ;
  logic         byteSelQ;

  assign wrEn = !csN && !iowN;
  assign rdEn = !csN && !iorN;

  // Ports below the status port form the channel block
  assign portChan   = regPort[2:1];
  assign portIsChan = (regPort < dmaPkg::PortStatus) && (int'(portChan) < NumChannels);
  assign addrHit    = portIsChan && (regPort[0] == dmaPkg::PortAddrBase[0]);
  assign countHit   = portIsChan && (regPort[0] == dmaPkg::PortCountBase[0]);

  assign modeChan = dataIn[1:0];
  assign stepOk   = stepReq && (int'(stepChan) < NumChannels) && !mask[stepChan];

  always_ff @(posedge dma_if or negedge rstN)
  begin
    if (!rstN)
    begin
      bytePtr     <= 1'b0;
      mask        <= 4'hf;
      wrAddrQ     <= '0;
      wrCountQ    <= '0;
      wrModeQ     <= '0;
      stepQ       <= '0;
      clearQ      <= 1'b0;
      statusClear <= 1'b0;
      readSrc     <= dmaPkg::ReadNone;
    end
    else
    begin
      wrAddrQ     <= '0;
      wrCountQ    <= '0;
      wrModeQ     <= '0;
      stepQ       <= '0;
      clearQ      <= 1'b0;
      statusClear <= 1'b0;
      readSrc     <= dmaPkg::ReadNone;

      // Every address or count access uses one byte
      if ((wrEn || rdEn) && portIsChan)
        bytePtr <= !bytePtr;

      if (wrEn)
      begin
        wrAddrQ[portChan]  <= addrHit;
        wrCountQ[portChan] <= countHit;
        case (regPort)
          dmaPkg::PortSingleMask:
            mask[modeChan] <= dataIn[dmaPkg::SingleMaskSetBit];
          dmaPkg::PortMode:
            if (int'(modeChan) < NumChannels)
              wrModeQ[modeChan] <= 1'b1;
          dmaPkg::PortClearFlipFlop:
            bytePtr <= 1'b0;
          dmaPkg::PortMasterClear:
          begin
            bytePtr     <= 1'b0;
            mask        <= 4'hf;
            clearQ      <= 1'b1;
            statusClear <= 1'b1;
          end
          dmaPkg::PortClearMask:
            mask <= 4'h0;
          dmaPkg::PortAllMask:
            mask <= dataIn[3:0];
          default:
            ;
        endcase
      end

      if (rdEn)
      begin
        if (addrHit)
          readSrc <= dmaPkg::ReadAddr;
        else if (countHit)
          readSrc <= dmaPkg::ReadCount;
        else if (regPort == dmaPkg::PortStatus)
        begin
          readSrc     <= dmaPkg::ReadStatus;
          statusClear <= 1'b1;
        end
      end

      if (stepOk)
        stepQ[stepChan] <= 1'b1;
    end
  end

  // Qualified by the strobes above
  always_ff @(posedge dma_if)
  begin
    wrDataQ  <= dataIn;
    byteSelQ <= bytePtr;
    readChan <= portChan;
  end

  assign readHi = byteSelQ;

  for (genvar i = 0; i < NumChannels; i++)
  begin : gChanBus
    assign chan[i].wrData  = wrDataQ;
    assign chan[i].hiByte  = byteSelQ;
    assign chan[i].wrAddr  = wrAddrQ[i];
    assign chan[i].wrCount = wrCountQ[i];
    assign chan[i].wrMode  = wrModeQ[i];
    assign chan[i].step    = stepQ[i];
    assign chan[i].clear   = clearQ;
  end

endmodule

`default_nettype wire

// ==== hw/dmaChannel.sv ====
// One DMA channel: base and current address and count, mode bits and step arithmetic
`timescale 1ns/1ps
`default_nettype none

module dmaChannel (
  input  logic       dma_if,
  input  logic       rstN,
  chanBusIf.channel  bus
);

  dmaPkg::addrWordT baseAddr;
  dmaPkg::addrWordT currAddr;
  dmaPkg::countT    baseCount;
  dmaPkg::countT    currCount;
  logic             autoInit;
  logic             decrement;
  logic             stopped;
  logic             stepOk;
  logic             countZero;
  dmaPkg::addrWordT nextAddr;

  assign stepOk    = bus.step && !stopped;
  assign countZero = (currCount == '0);
  assign nextAddr  = decrement ? currAddr - 16'd1 : currAddr + 16'd1;

  always_ff @(posedge dma_if or negedge rstN)
  begin
    if (!rstN)
    begin
      baseAddr     <= '0;
      currAddr     <= '0;
      baseCount    <= '0;
      currCount    <= '0;
      autoInit     <= 1'b0;
      decrement    <= 1'b0;
      stopped      <= 1'b0;
      bus.stepDone <= 1'b0;
      bus.tcHit    <= 1'b0;
    end
    else if (bus.clear)
    begin
      baseAddr     <= '0;
      currAddr     <= '0;
      baseCount    <= '0;
      currCount    <= '0;
      autoInit     <= 1'b0;
      decrement    <= 1'b0;
      stopped      <= 1'b0;
      bus.stepDone <= 1'b0;
      bus.tcHit    <= 1'b0;
    end
    else
    begin
      bus.stepDone <= stepOk;
      bus.tcHit    <= stepOk && countZero;

      if (stepOk)
      begin
        // Count passing zero ends the block
        if (countZero && autoInit)
        begin
          currAddr  <= baseAddr;
          currCount <= baseCount;
        end
        else
        begin
          currAddr  <= nextAddr;
          currCount <= currCount - 16'd1;
          if (countZero)
            stopped <= 1'b1;
        end
      end

      // Register writes load base and current together
      if (bus.wrAddr)
      begin
        if (bus.hiByte)
        begin
          baseAddr[15:8] <= bus.wrData;
          currAddr[15:8] <= bus.wrData;
        end
        else
        begin
          baseAddr[7:0] <= bus.wrData;
          currAddr[7:0] <= bus.wrData;
        end
      end

      if (bus.wrCount)
      begin
        stopped <= 1'b0;
        if (bus.hiByte)
        begin
          baseCount[15:8] <= bus.wrData;
          currCount[15:8] <= bus.wrData;
        end
        else
        begin
          baseCount[7:0] <= bus.wrData;
          currCount[7:0] <= bus.wrData;
        end
      end

      if (bus.wrMode)
      begin
        autoInit  <= bus.wrData[dmaPkg::ModeAutoInitBit];
        decrement <= bus.wrData[dmaPkg::ModeDecrementBit];
      end
    end
  end

  // Address of the step, valid with stepDone
  always_ff @(posedge dma_if)
  begin
    if (stepOk)
      bus.stepAddr <= currAddr;
  end

  assign bus.currAddr  = currAddr;
  assign bus.currCount = currCount;

endmodule

`default_nettype wire

// ==== hw/readbackMux.sv ====
// Readback stage: sticky TC status, CPU read data and the merged memory address output
`timescale 1ns/1ps
`default_nettype none

module readbackMux #(
  parameter int NumChannels = 4
) (
  input  logic              dma_if,
  input  logic              rstN,
  input  dmaPkg::readSrcT   readSrc,
  input  dmaPkg::chanT      readChan,
  input  logic              readHi,
  input  logic              statusClear,
  chanBusIf.readback        chan [NumChannels],
  output dmaPkg::byteT      dataOut,
  output logic              readValid,
  output dmaPkg::addrWordT  memAddr,
  output logic              memValid,
  output logic              tc
);

  dmaPkg::addrWordT       chanAddr [NumChannels];
  dmaPkg::countT          chanCount [NumChannels];
  dmaPkg::addrWordT       chanStep [NumChannels];
  logic [NumChannels-1:0] doneVec;
  logic [NumChannels-1:0] tcVec;
  logic [3:0]             tcHits;
  logic [3:0]             tcFlags;
  logic [15:0]            selWord;
  dmaPkg::byteT           rdByte;
  dmaPkg::addrWordT       stepWord;

  for (genvar i = 0; i < NumChannels; i++)
  begin : gGather
    assign chanAddr[i]  = chan[i].currAddr;
    assign chanCount[i] = chan[i].currCount;
    assign chanStep[i]  = chan[i].stepAddr;
    assign doneVec[i]   = chan[i].stepDone;
    assign tcVec[i]     = chan[i].tcHit;
  end

  assign tcHits = 4'(tcVec);

  always_comb
  begin
    selWord = (readSrc == dmaPkg::ReadCount) ? chanCount[readChan] : chanAddr[readChan];
    if (readSrc == dmaPkg::ReadStatus)
      rdByte = {4'h0, tcFlags};
    else
      rdByte = readHi ? selWord[15:8] : selWord[7:0];
  end

  // At most one channel steps per cycle, so OR is enough
  always_comb
  begin
    stepWord = '0;
    for (int i = 0; i < NumChannels; i++)
      if (doneVec[i])
        stepWord = stepWord | chanStep[i];
  end

  always_ff @(posedge dma_if or negedge rstN)
  begin
    if (!rstN)
    begin
      tcFlags   <= 4'h0;
      readValid <= 1'b0;
      memValid  <= 1'b0;
      tc        <= 1'b0;
    end
    else
    begin
      // New terminal count beats the clear
      tcFlags   <= (tcFlags & {4{!statusClear}}) | tcHits;
      readValid <= (readSrc != dmaPkg::ReadNone);
      memValid  <= |doneVec;
      tc        <= |tcVec;
    end
  end

  always_ff @(posedge dma_if)
  begin
    dataOut <= rdByte;
    memAddr <= stepWord;
  end

endmodule

`default_nettype wire

// ==== hw/dmaDatapath.sv ====
// DMA datapath top level: CPU port decoder, channel array and readback stage on plain ports
`timescale 1ns/1ps
`default_nettype none

module dmaDatapath #(
  parameter int NumChannels = 4
) (
  input  logic              dma_if,
  input  logic              rstN,
  input  logic              csN,
  input  logic              iorN,
  input  logic              iowN,
  input  dmaPkg::regPortT   regPort,
  input  dmaPkg::byteT      dataIn,
  input  logic              stepReq,
  input  dmaPkg::chanT      stepChan,
  output dmaPkg::byteT      dataOut,
  output logic              readValid,
  output dmaPkg::addrWordT  memAddr,
  output logic              memValid,
  output logic              tc
);

  // Decoder to readback sideband
  dmaPkg::readSrcT readSrc;
  dmaPkg::chanT    readChan;
  logic            readHi;
  logic            statusClear;

  chanBusIf chanBus [NumChannels] ();

  cpuPortDecoder #(
    .NumChannels (NumChannels)
  ) uDecoder (
    .dma_if      (dma_if),
    .rstN        (rstN),
    .csN         (csN),
    .iorN        (iorN),
    .iowN        (iowN),
    .regPort     (regPort),
    .dataIn      (dataIn),
    .stepReq     (stepReq),
    .stepChan    (stepChan),
    .readSrc     (readSrc),
    .readChan    (readChan),
    .readHi      (readHi),
    .statusClear (statusClear),
    .chan        (chanBus)
  );

  for (genvar i = 0; i < NumChannels; i++)
  begin : gChannel
    dmaChannel uChannel (
      .dma_if (dma_if),
      .rstN   (rstN),
      .bus    (chanBus[i])
    );
  end

  readbackMux #(
    .NumChannels (NumChannels)
  ) uReadback (
    .dma_if      (dma_if),
    .rstN        (rstN),
    .readSrc     (readSrc),
    .readChan    (readChan),
    .readHi      (readHi),
    .statusClear (statusClear),
    .chan        (chanBus),
    .dataOut     (dataOut),
    .readValid   (readValid),
    .memAddr     (memAddr),
    .memValid    (memValid),
    .tc          (tc)
  );

endmodule

`default_nettype wire

// ==== test/dmaDatapath_properties.sv ====
// Concurrent checks on the DMA datapath strobes, bound into every dmaDatapath instance
`timescale 1ns/1ps
`default_nettype none

module dmaDatapath_properties (
  input logic            dma_if,
  input logic            rstN,
  input logic            csN,
  input logic            iorN,
  input dmaPkg::regPortT regPort,
  input logic            stepReq,
  input logic            readValid,
  input logic            memValid,
  input logic            tc
);

  // Number of failed assertions so far
  int assertFails = 0;

  readValidPulse: assert property (@(posedge dma_if) disable iff (!rstN)
    readValid |=> !readValid)
  else
  begin
    assertFails++;
    $error("readValid stayed high for more than one cycle");
  end

  tcPulse: assert property (@(posedge dma_if) disable iff (!rstN) tc |=> !tc)
  else
  begin
    assertFails++;
    $error("tc stayed high for more than one cycle");
  end

  tcWithStep: assert property (@(posedge dma_if) disable iff (!rstN) tc |-> memValid)
  else
  begin
    assertFails++;
    $error("tc without memValid");
  end

  // Each memValid trails its step request by three cycles
  stepLatency: assert property (@(posedge dma_if) disable iff (!rstN)
    memValid |-> $past(stepReq, 3))
  else
  begin
    assertFails++;
    $error("memValid without a step request three cycles earlier");
  end

  readLatency: assert property (@(posedge dma_if) disable iff (!rstN)
    (!csN && !iorN && regPort <= dmaPkg::PortStatus) |-> ##2 readValid)
  else
  begin
    assertFails++;
    $error("readValid missing two cycles after a register read");
  end

endmodule

bind dmaDatapath dmaDatapath_properties uProps (
  .dma_if    (dma_if),
  .rstN      (rstN),
  .csN       (csN),
  .iorN      (iorN),
  .regPort   (regPort),
  .stepReq   (stepReq),
  .readValid (readValid),
  .memValid  (memValid),
  .tc        (tc)
);

`default_nettype wire

// ==== test/dmaTb.sv ====
// Testbench for the DMA datapath that programs channels over the CPU port, steps them and checks results
`timescale 1ns/1ps
`default_nettype none

module dmaTb;

  // Upper bounds on the run length for the timeout
  localparam int ResetCycles   = 16;
  localparam int BusAccesses   = 64;
  localparam int AccessCycles  = 5;
  localparam int StepCycles    = 110;
  localparam int TestCycles    = ResetCycles + BusAccesses * AccessCycles + StepCycles;
  localparam int TimeoutCycles = 2 * TestCycles;

  logic             dma_if;
  logic             rstN;
  logic             csN;
  logic             iorN;
  logic             iowN;
  dmaPkg::regPortT  regPort;
  dmaPkg::byteT     dataIn;
  logic             stepReq;
  dmaPkg::chanT     stepChan;
  dmaPkg::byteT     dataOut;
  logic             readValid;
  dmaPkg::addrWordT memAddr;
  logic             memValid;
  logic             tc;

  // Reference model of the four channels
  dmaPkg::addrWordT mBaseAddr [4];
  dmaPkg::addrWordT mCurrAddr [4];
  dmaPkg::countT    mBaseCount [4];
  dmaPkg::countT    mCurrCount [4];
  logic [3:0]       mAutoInit;
  logic [3:0]       mDecrement;
  logic [3:0]       mStopped;
  logic [3:0]       mMask;
  logic [3:0]       mStatus;
  logic             mBytePtr;

  // Expected responses in arrival order
  dmaPkg::byteT     expByte [$];
  dmaPkg::addrWordT expAddr [$];
  logic             expTc [$];

  logic [31:0] lcgState = 32'h7dce_6224;
  string       testName = "reset";
  int          byteErrors = 0;
  int          addrErrors = 0;
  int          flagErrors = 0;
  int          missingErrors = 0;
  int          cycleCount = 0;

  dmaDatapath #(
    .NumChannels (4)
  ) DUT (
    .dma_if    (dma_if),
    .rstN      (rstN),
    .csN       (csN),
    .iorN      (iorN),
    .iowN      (iowN),
    .regPort   (regPort),
    .dataIn    (dataIn),
    .stepReq   (stepReq),
    .stepChan  (stepChan),
    .dataOut   (dataOut),
    .readValid (readValid),
    .memAddr   (memAddr),
    .memValid  (memValid),
    .tc        (tc)
  );

  initial
  begin
    dma_if = 1'b0;
    forever
      #50 dma_if = !dma_if;
  end

  initial
  begin
    while (cycleCount < TimeoutCycles)
    begin
      @(posedge dma_if);
      cycleCount++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
    $display("=== FAIL ===");
    $finish;
  end

  function automatic logic [31:0] nextRandom();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  function automatic dmaPkg::regPortT addrPort(input dmaPkg::chanT ch);
    return {1'b0, ch, 1'b0} | dmaPkg::PortAddrBase;
  endfunction

  function automatic dmaPkg::regPortT countPort(input dmaPkg::chanT ch);
    return {1'b0, ch, 1'b0} | dmaPkg::PortCountBase;
  endfunction

  function automatic logic [15:0] setByte(input logic [15:0] word, input logic hi,
                                          input dmaPkg::byteT data);
    logic [15:0] result;
    result = word;
    if (hi)
      result[15:8] = data;
    else
      result[7:0] = data;
    return result;
  endfunction

  // State after reset or master clear
  function automatic void clearModel();
    mBaseAddr  = '{default: 16'h0};
    mCurrAddr  = '{default: 16'h0};
    mBaseCount = '{default: 16'h0};
    mCurrCount = '{default: 16'h0};
    mAutoInit  = 4'h0;
    mDecrement = 4'h0;
    mStopped   = 4'h0;
    mMask      = 4'hf;
    mStatus    = 4'h0;
    mBytePtr   = 1'b0;
  endfunction

  function automatic void modelWrite(input dmaPkg::regPortT port, input dmaPkg::byteT data);
    dmaPkg::chanT ch;
    ch = port[2:1];
    if (port < dmaPkg::PortStatus)
    begin
      if (port[0] == dmaPkg::PortAddrBase[0])
      begin
        mBaseAddr[ch] = setByte(mBaseAddr[ch], mBytePtr, data);
        mCurrAddr[ch] = setByte(mCurrAddr[ch], mBytePtr, data);
      end
      else
      begin
        mBaseCount[ch] = setByte(mBaseCount[ch], mBytePtr, data);
        mCurrCount[ch] = setByte(mCurrCount[ch], mBytePtr, data);
        mStopped[ch]   = 1'b0;
      end
      mBytePtr = !mBytePtr;
    end
    else
    begin
      case (port)
        dmaPkg::PortSingleMask:
          mMask[data[1:0]] = data[dmaPkg::SingleMaskSetBit];
        dmaPkg::PortMode:
        begin
          mAutoInit[data[1:0]]  = data[dmaPkg::ModeAutoInitBit];
          mDecrement[data[1:0]] = data[dmaPkg::ModeDecrementBit];
        end
        dmaPkg::PortClearFlipFlop:
          mBytePtr = 1'b0;
        dmaPkg::PortMasterClear:
          clearModel();
        dmaPkg::PortClearMask:
          mMask = 4'h0;
        dmaPkg::PortAllMask:
          mMask = data[3:0];
        default:
          ;
      endcase
    end
  endfunction

  // Status read clears the TC flags
  function automatic dmaPkg::byteT modelRead(input dmaPkg::regPortT port);
    dmaPkg::chanT ch;
    logic [15:0]  word;
    dmaPkg::byteT result;
    ch = port[2:1];
    if (port == dmaPkg::PortStatus)
    begin
      result  = {4'h0, mStatus};
      mStatus = 4'h0;
    end
    else
    begin
      word     = port[0] ? mCurrCount[ch] : mCurrAddr[ch];
      result   = mBytePtr ? word[15:8] : word[7:0];
      mBytePtr = !mBytePtr;
    end
    return result;
  endfunction

  // Returns 1 when the step is accepted
  function automatic logic modelStep(input dmaPkg::chanT ch, output dmaPkg::addrWordT addr,
                                     output logic tcOut);
    addr  = mCurrAddr[ch];
    tcOut = 1'b0;
    if (mMask[ch] || mStopped[ch])
      return 1'b0;
    tcOut = (mCurrCount[ch] == 16'h0);
    if (tcOut)
      mStatus[ch] = 1'b1;
    if (tcOut && mAutoInit[ch])
    begin
      mCurrAddr[ch]  = mBaseAddr[ch];
      mCurrCount[ch] = mBaseCount[ch];
    end
    else
    begin
      mCurrAddr[ch]  = mDecrement[ch] ? mCurrAddr[ch] - 16'd1 : mCurrAddr[ch] + 16'd1;
      mCurrCount[ch] = mCurrCount[ch] - 16'd1;
      if (tcOut)
        mStopped[ch] = 1'b1;
    end
    return 1'b1;
  endfunction

  task automatic busWrite(input dmaPkg::regPortT port, input dmaPkg::byteT data);
    @(negedge dma_if);
    csN     = 1'b0;
    iowN    = 1'b0;
    regPort = port;
    dataIn  = data;
    modelWrite(port, data);
    @(negedge dma_if);
    csN  = 1'b1;
    iowN = 1'b1;
    repeat (3) @(negedge dma_if);
  endtask

  task automatic busRead(input dmaPkg::regPortT port);
    @(negedge dma_if);
    csN     = 1'b0;
    iorN    = 1'b0;
    regPort = port;
    expByte.push_back(modelRead(port));
    @(negedge dma_if);
    csN  = 1'b1;
    iorN = 1'b1;
    repeat (3) @(negedge dma_if);
  endtask

  task automatic programWord(input dmaPkg::regPortT port, input logic [15:0] value);
    busWrite(port, value[7:0]);
    busWrite(port, value[15:8]);
  endtask

  task automatic readWord(input dmaPkg::regPortT port);
    busRead(port);
    busRead(port);
  endtask

  // Back-to-back step requests followed by a drain gap
  task automatic stepBurst(input dmaPkg::chanT ch, input int steps);
    dmaPkg::addrWordT addr;
    logic             tcOut;
    for (int i = 0; i < steps; i++)
    begin
      @(negedge dma_if);
      stepReq  = 1'b1;
      stepChan = ch;
      if (modelStep(ch, addr, tcOut))
      begin
        expAddr.push_back(addr);
        expTc.push_back(tcOut);
      end
    end
    @(negedge dma_if);
    stepReq = 1'b0;
    repeat (4) @(negedge dma_if);
  endtask

  task automatic checkByte(input string name, input dmaPkg::byteT expected,
                           input dmaPkg::byteT actual);
    if (actual !== expected)
    begin
      byteErrors++;
      $display("Mismatch %s: expected 0x%02h, actual 0x%02h", name, expected, actual);
    end
  endtask

  task automatic checkAddr(input string name, input dmaPkg::addrWordT expected,
                           input dmaPkg::addrWordT actual);
    if (actual !== expected)
    begin
      addrErrors++;
      $display("Mismatch %s: expected 0x%04h, actual 0x%04h", name, expected, actual);
    end
  endtask

  task automatic checkFlag(input string name, input logic expected, input logic actual);
    if (actual !== expected)
    begin
      flagErrors++;
      $display("Mismatch %s: expected tc %0b, actual tc %0b", name, expected, actual);
    end
  endtask

  // Registered outputs are stable at the falling edge
  initial
  begin
    forever
    begin
      @(negedge dma_if);
      if (readValid)
      begin
        if (expByte.size() == 0)
        begin
          byteErrors++;
          $display("Read data 0x%02h arrived in %s with no read pending", dataOut, testName);
        end
        else
          checkByte(testName, expByte.pop_front(), dataOut);
      end
    end
  end

  initial
  begin
    forever
    begin
      @(negedge dma_if);
      if (memValid)
      begin
        if (expAddr.size() == 0)
        begin
          addrErrors++;
          $display("Step output 0x%04h in %s for a step that should be dropped", memAddr,
                   testName);
        end
        else
          checkAddr(testName, expAddr.pop_front(), memAddr);
      end
    end
  end

  initial
  begin
    forever
    begin
      @(negedge dma_if);
      if (tc && !memValid)
      begin
        flagErrors++;
        $display("Terminal count raised without a step output in %s", testName);
      end
      else if (memValid && expTc.size() != 0)
        checkFlag(testName, expTc.pop_front(), tc);
    end
  end

  initial
  begin : runTests
    logic [31:0]   r;
    dmaPkg::countT cnt;
    rstN     = 1'b0;
    csN      = 1'b1;
    iorN     = 1'b1;
    iowN     = 1'b1;
    regPort  = '0;
    dataIn   = '0;
    stepReq  = 1'b0;
    stepChan = '0;
    clearModel();
    repeat (ResetCycles) @(posedge dma_if);
    @(negedge dma_if);
    rstN = 1'b1;

    testName = "register readback";
    for (int i = 0; i < 4; i++)
    begin
      r = nextRandom();
      programWord(addrPort(dmaPkg::chanT'(i)), r[31:16]);
      r = nextRandom();
      programWord(countPort(dmaPkg::chanT'(i)), r[31:16]);
    end
    for (int i = 0; i < 4; i++)
    begin
      readWord(addrPort(dmaPkg::chanT'(i)));
      readWord(countPort(dmaPkg::chanT'(i)));
    end
    // Pointer left on the high byte and then cleared
    busRead(addrPort(2'd0));
    busWrite(dmaPkg::PortClearFlipFlop, 8'h00);
    readWord(addrPort(2'd0));

    testName = "increment to terminal count";
    busWrite(dmaPkg::PortMode, 8'h02);
    r   = nextRandom();
    cnt = {13'd0, r[15:13]} + 16'd3;
    programWord(addrPort(2'd2), r[31:16]);
    programWord(countPort(2'd2), cnt);
    busWrite(dmaPkg::PortClearMask, 8'h00);
    stepBurst(2'd2, int'(cnt) + 1);
    stepBurst(2'd2, 2);

    testName = "decrement with auto-initialize";
    busWrite(dmaPkg::PortMode, 8'h31);
    r   = nextRandom();
    cnt = {13'd0, r[15:13]} + 16'd2;
    programWord(addrPort(2'd1), r[31:16]);
    programWord(countPort(2'd1), cnt);
    stepBurst(2'd1, 2 * (int'(cnt) + 1) + 2);

    testName = "status read";
    busRead(dmaPkg::PortStatus);
    busRead(dmaPkg::PortStatus);

    testName = "channel masks";
    busWrite(dmaPkg::PortSingleMask, 8'h04);
    stepBurst(2'd0, 2);
    busWrite(dmaPkg::PortSingleMask, 8'h00);
    stepBurst(2'd0, 2);
    busWrite(dmaPkg::PortAllMask, 8'h06);
    for (int i = 0; i < 4; i++)
      stepBurst(dmaPkg::chanT'(i), 1);

    testName = "master clear";
    busWrite(addrPort(2'd3), 8'h5a);
    busWrite(dmaPkg::PortMasterClear, 8'h00);
    // Lands in the low byte only if the pointer was reset
    busWrite(addrPort(2'd3), 8'ha5);
    readWord(addrPort(2'd3));
    readWord(countPort(2'd3));
    busRead(dmaPkg::PortStatus);
    stepBurst(2'd3, 2);

    repeat (6) @(negedge dma_if);
    if (expByte.size() + expAddr.size() != 0)
    begin
      missingErrors++;
      $display("Responses never arrived: %0d read bytes and %0d step outputs still pending",
               expByte.size(), expAddr.size());
    end
    $display("Errors: read data %0d, step address %0d, tc %0d, missing %0d, assertions %0d",
             byteErrors, addrErrors, flagErrors, missingErrors, DUT.uProps.assertFails);
    if (byteErrors + addrErrors + flagErrors + missingErrors + DUT.uProps.assertFails == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
hw/dmaPkg.sv
hw/chanBusIf.sv
hw/cpuPortDecoder.sv
hw/dmaChannel.sv
hw/readbackMux.sv
hw/dmaDatapath.sv
test/dmaDatapath_properties.sv
test/dmaTb.sv

// ==== Makefile ====
SOURCES := $(shell cat filelist.f)

.PHONY: run clean

run: obj_dir/VdmaTb
	@out="$$(./obj_dir/VdmaTb +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '=== PASS ==='

obj_dir/VdmaTb: filelist.f $(SOURCES)
	verilator --binary --timing --assert --top-module dmaTb -f filelist.f -o VdmaTb

clean:
	rm -rf obj_dir
